//--- hw/usb_phy_pkg.sv
// USB PHY shared definitions

package usb_phy_pkg;

	// ------------------------------
	// line state
	// ------------------------------

	// the state of one port's pair, formed as {D-, D+}.
	// full-speed idle is j, with D+ pulled high by the device.
	typedef enum logic [1:0] {
		se0 = 2'b00,
		j   = 2'b01,
		k   = 2'b10,
		se1 = 2'b11
	} line_state_t;

	// ------------------------------
	// framing constants
	// ------------------------------

	// usb_clk cycles per 12 Mbit/s bit at 48 MHz.
	localparam logic [2:0] OVERSAMPLE = 3'd4;

	// sent least significant bit first, this gives KJKJKJKK on the line.
	localparam logic [7:0] SYNC_BYTE = 8'h80;

	// after this many ones in a row a zero is inserted.
	localparam logic [2:0] STUFF_LIMIT = 3'd6;

endpackage

//--- hw/usb_line_filter.sv
// USB line input filter
`timescale 1ns/1ps

module usb_line_filter import usb_phy_pkg::*; (
	input  logic        usb_clk,
	input  logic        usb_rst,
	input  logic        vp,
	input  logic        vm,
	output line_state_t line_state
);

	// two synchronizer stages, each holding {vm, vp}.
	logic [1:0] sync_q1;
	logic [1:0] sync_q2;
	// the two synchronized samples that came before sync_q2.
	logic [1:0] hist_q1;
	logic [1:0] hist_q2;

	// the raw pins are asynchronous to usb_clk, so they pass two flops first.
	// the output then only follows when three samples in a row agree, which
	// hides any glitch shorter than three cycles.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			sync_q1    <= j;
			sync_q2    <= j;
			hist_q1    <= j;
			hist_q2    <= j;
			line_state <= j;
		end else begin
			sync_q1 <= {vm, vp};
			sync_q2 <= sync_q1;
			hist_q1 <= sync_q2;
			hist_q2 <= hist_q1;
			// otherwise the last agreed state is held.
			if ((sync_q2 == hist_q1) && (hist_q1 == hist_q2)) begin
				line_state <= line_state_t'(sync_q2);
			end
		end
	end

endmodule

//--- hw/usb_discon_detect.sv
// USB disconnect detector
`timescale 1ns/1ps

module usb_discon_detect import usb_phy_pkg::*; #(
	parameter int DISCON_CYCLES = 120
) (
	input  logic        usb_clk,
	input  logic        usb_rst,
	input  line_state_t line_state,
	output logic        discon
);

	localparam int CNT_W = $clog2(DISCON_CYCLES + 1);

	// consecutive cycles of se0 seen so far, saturating at DISCON_CYCLES.
	logic [CNT_W-1:0] se0_cnt;

	// with no device on the port the pull-downs hold the pair at se0.
	// any other line state means something is attached, so the count restarts.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			se0_cnt <= '0;
		end else if (line_state != se0) begin
			se0_cnt <= '0;
		end else if (se0_cnt != CNT_W'(DISCON_CYCLES)) begin
			se0_cnt <= se0_cnt + 1'b1;
		end
	end

	// the counter only clears on the next edge, so the line state itself
	// also qualifies the flag to drop it as soon as the port leaves se0.
	assign discon = (se0_cnt == CNT_W'(DISCON_CYCLES)) && (line_state == se0);

endmodule

//--- hw/usb_tx.sv
// USB full-speed transmitter
`timescale 1ns/1ps

module usb_tx import usb_phy_pkg::*; (
	input  logic       usb_clk,
	input  logic       usb_rst,
	input  logic [7:0] tx_data,
	input  logic       tx_valid,
	input  logic       generate_reset,
	output logic       tx_ready,
	output logic       txp,
	output logic       txm,
	output logic       txoe
);

	typedef enum logic [2:0] {
		st_idle,
		st_sync,
		st_data,
		st_eop,
		st_reset
	} tx_state_t;

	// last cycle of a bit time, counted from zero.
	localparam logic [1:0] div_last = 2'(OVERSAMPLE - 3'd1);

	tx_state_t  state;
	logic [1:0] div;
	logic [7:0] sr;
	logic [2:0] cnt;
	logic [2:0] ones;
	logic       first_req;
	logic       buf_full;
	logic [7:0] data_buf;
	logic       tick;
	logic       stuff_now;
	logic       byte_end;
	logic [7:0] ld_byte;
	logic       ld_ok;

	// ------------------------------
	// next bit selection
	// ------------------------------

	// a new line symbol is chosen on the last cycle of each bit time.
	// cnt holds the bits still waiting in sr, so zero marks a byte boundary.
	// after sync the first byte comes from the buffer, later ones straight from tx_data.
	always_comb begin
		tick      = (state == st_sync || state == st_data || state == st_eop) &&
		            (div == div_last);
		stuff_now = (ones == STUFF_LIMIT);
		byte_end  = (cnt == 3'd0);
		ld_byte   = (state == st_sync) ? data_buf : tx_data;
		ld_ok     = (state == st_sync) ? buf_full : tx_valid;
		tx_ready  = (first_req & tx_valid) |
		            (tick & (state == st_data) & ~stuff_now & byte_end & tx_valid);
	end

	// the first byte is taken while sync is still on the line.
	always_ff @(posedge usb_clk) begin
		if (first_req && tx_valid) begin
			data_buf <= tx_data;
		end
	end

	// ------------------------------
	// state machine and line driver
	// ------------------------------

	// NRZI keeps the level for a one and toggles it for a zero. With txm equal to
	// ~txp in j and k, the new pair for bit b is {txp ^ b, txp ^ ~b}.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state     <= st_idle;
			div       <= 2'd0;
			cnt       <= 3'd0;
			ones      <= 3'd0;
			first_req <= 1'b0;
			buf_full  <= 1'b0;
			txoe      <= 1'b0;
			txp       <= 1'b1;
			txm       <= 1'b0;
		end else begin
			div       <= (state == st_idle) ? 2'd0 : div + 2'd1;
			first_req <= 1'b0;
			if (first_req) begin
				buf_full <= tx_valid;
			end
			case (state)
				st_idle: begin
					// bus reset wins over a pending packet.
					if (generate_reset) begin
						state <= st_reset;
						txoe  <= 1'b1;
						txp   <= 1'b0;
						txm   <= 1'b0;
					end else if (tx_valid) begin
						// the first sync bit goes out together with txoe.
						state     <= st_sync;
						txoe      <= 1'b1;
						first_req <= 1'b1;
						buf_full  <= 1'b0;
						sr        <= SYNC_BYTE >> 1;
						cnt       <= 3'd7;
						ones      <= SYNC_BYTE[0] ? 3'd1 : 3'd0;
						txp       <= txp ^ ~SYNC_BYTE[0];
						txm       <= txp ^ SYNC_BYTE[0];
					end
				end
				st_sync, st_data: begin
					if (tick) begin
						if (stuff_now) begin
							// stuffed zero, nothing leaves the shift register.
							ones <= 3'd0;
							txp  <= ~txp;
							txm  <= txp;
						end else if (!byte_end) begin
							sr   <= sr >> 1;
							cnt  <= cnt - 3'd1;
							ones <= sr[0] ? ones + 3'd1 : 3'd0;
							txp  <= txp ^ ~sr[0];
							txm  <= txp ^ sr[0];
						end else if (ld_ok) begin
							state <= st_data;
							sr    <= ld_byte >> 1;
							cnt   <= 3'd7;
							ones  <= ld_byte[0] ? ones + 3'd1 : 3'd0;
							txp   <= txp ^ ~ld_byte[0];
							txm   <= txp ^ ld_byte[0];
						end else begin
							// no byte for this boundary, so the packet ends.
							state <= st_eop;
							cnt   <= 3'd0;
							txp   <= 1'b0;
							txm   <= 1'b0;
						end
					end
				end
				st_eop: begin
					// two bit times of se0, one of j, then release the pair.
					if (tick) begin
						if (cnt == 3'd0) begin
							cnt <= 3'd1;
						end else if (cnt == 3'd1) begin
							cnt <= 3'd2;
							txp <= 1'b1;
							txm <= 1'b0;
						end else begin
							state <= st_idle;
							txoe  <= 1'b0;
						end
					end
				end
				default: begin
					// bus reset lasts as long as the request does.
					if (!generate_reset) begin
						state <= st_idle;
						txoe  <= 1'b0;
						txp   <= 1'b1;
						txm   <= 1'b0;
					end
				end
			endcase
		end
	end

endmodule

//--- hw/usb_rx.sv
// USB full-speed receiver
`timescale 1ns/1ps

module usb_rx import usb_phy_pkg::*; (
	input  logic        usb_clk,
	input  logic        usb_rst,
	input  logic        rxen,
	input  line_state_t line_state,
	output logic [7:0]  rx_data,
	output logic        rx_valid,
	output logic        rx_active
);

	// sampling point, half a bit time after the last edge.
	localparam logic [1:0] sample_phase = 2'(OVERSAMPLE >> 1);

	line_state_t ls_q;
	logic [1:0]  phase;
	logic        prev_dp;
	logic [2:0]  ones;
	logic [2:0]  bitcnt;
	logic [7:0]  shreg;
	logic        trans;
	logic        sample;
	logic        rx_bit;
	logic [7:0]  shreg_nxt;

	// ------------------------------
	// bit phase recovery
	// ------------------------------

	// every j/k edge restarts the phase count. The bit is taken two cycles later
	// and then every four cycles while the line holds still.
	always_comb begin
		trans     = ((ls_q == j) && (line_state == k)) || ((ls_q == k) && (line_state == j));
		sample    = (phase == sample_phase) && !trans;
		// no change since the last sample decodes as a one.
		rx_bit    = (line_state[0] == prev_dp);
		shreg_nxt = {rx_bit, shreg[7:1]};
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			ls_q  <= j;
			phase <= 2'd0;
		end else begin
			ls_q  <= line_state;
			phase <= trans ? 2'd1 : phase + 2'd1;
		end
	end

	// ------------------------------
	// decode, destuff and assemble
	// ------------------------------

	// bits arrive least significant first, so they enter shreg from the top.
	// the same register hunts for sync and then gathers the data bytes.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			prev_dp   <= 1'b1;
			ones      <= 3'd0;
			bitcnt    <= 3'd0;
			rx_valid  <= 1'b0;
			rx_active <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!rxen) begin
				// our own transmission is on the pair, the idle level follows it.
				prev_dp   <= 1'b1;
				ones      <= 3'd0;
				rx_active <= 1'b0;
			end else if (sample) begin
				if (line_state == se0 || line_state == se1) begin
					// end of packet. Any partial byte is dropped.
					rx_active <= 1'b0;
				end else begin
					prev_dp <= line_state[0];
					if (!rx_active) begin
						// hunting for sync, the ones count runs but nothing is removed.
						shreg <= shreg_nxt;
						if (!rx_bit) begin
							ones <= 3'd0;
						end else if (ones != 3'd7) begin
							ones <= ones + 3'd1;
						end
						if (shreg_nxt == SYNC_BYTE) begin
							rx_active <= 1'b1;
							bitcnt    <= 3'd0;
						end
					end else if (ones == STUFF_LIMIT) begin
						// this bit must be a stuffed zero. A one here is an error.
						ones <= 3'd0;
						if (rx_bit) begin
							rx_active <= 1'b0;
						end
					end else begin
						shreg  <= shreg_nxt;
						ones   <= rx_bit ? ones + 3'd1 : 3'd0;
						bitcnt <= bitcnt + 3'd1;
						rx_valid <= (bitcnt == 3'd7);
					end
				end
			end
		end
	end

	// the byte is complete in the cycle rx_valid is high.
	assign rx_data = shreg;

endmodule

//--- hw/usb_phy.sv
// USB two-port PHY top level
`timescale 1ns/1ps

module usb_phy import usb_phy_pkg::*; #(
	parameter int DISCON_CYCLES = 120
) (
	input  logic        usb_clk,
	input  logic        usb_rst,

	input  logic        usba_vp_in,
	input  logic        usba_vm_in,
	output logic        usba_vp_out,
	output logic        usba_vm_out,
	output logic        usba_oe_n,

	input  logic        usbb_vp_in,
	input  logic        usbb_vm_in,
	output logic        usbb_vp_out,
	output logic        usbb_vm_out,
	output logic        usbb_oe_n,

	output logic        usba_discon,
	output logic        usbb_discon,

	output line_state_t line_state_a,
	output line_state_t line_state_b,

	input  logic        port_sel_rx,
	input  logic [1:0]  port_sel_tx,

	input  logic [7:0]  tx_data,
	input  logic        tx_valid,
	output logic        tx_ready,
	input  logic        generate_reset,

	output logic [7:0]  rx_data,
	output logic        rx_valid,
	output logic        rx_active
);

	logic        txp;
	logic        txm;
	logic        txoe;
	line_state_t rx_line_state;

	// ------------------------------
	// line inputs
	// ------------------------------

	usb_line_filter filter_a_i (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.vp         (usba_vp_in),
		.vm         (usba_vm_in),
		.line_state (line_state_a)
	);

	usb_line_filter filter_b_i (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.vp         (usbb_vp_in),
		.vm         (usbb_vm_in),
		.line_state (line_state_b)
	);

	// a long se0 means the device has gone, about 2.5 us by default.
	usb_discon_detect #(
		.DISCON_CYCLES (DISCON_CYCLES)
	) discon_a_i (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.line_state (line_state_a),
		.discon     (usba_discon)
	);

	usb_discon_detect #(
		.DISCON_CYCLES (DISCON_CYCLES)
	) discon_b_i (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.line_state (line_state_b),
		.discon     (usbb_discon)
	);

	// ------------------------------
	// transmit and receive
	// ------------------------------

	usb_tx tx_i (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.tx_data        (tx_data),
		.tx_valid       (tx_valid),
		.generate_reset (generate_reset),
		.tx_ready       (tx_ready),
		.txp            (txp),
		.txm            (txm),
		.txoe           (txoe)
	);

	// only one port is listened to at a time.
	assign rx_line_state = port_sel_rx ? line_state_b : line_state_a;

	// the receiver is off while the transmitter owns any pair.
	usb_rx rx_i (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.rxen       (~txoe),
		.line_state (rx_line_state),
		.rx_data    (rx_data),
		.rx_valid   (rx_valid),
		.rx_active  (rx_active)
	);

	// both ports see the same symbols, the enables pick which pads drive.
	assign usba_vp_out = txp;
	assign usba_vm_out = txm;
	assign usbb_vp_out = txp;
	assign usbb_vm_out = txm;
	assign usba_oe_n   = ~(txoe & port_sel_tx[0]);
	assign usbb_oe_n   = ~(txoe & port_sel_tx[1]);

endmodule

//--- sim/usb_phy_chk.sv
// USB PHY interface assertions
`timescale 1ns/1ps

module usb_phy_chk import usb_phy_pkg::*; (
	input logic        usb_clk,
	input logic        usb_rst,
	input logic        rx_valid,
	input logic        rx_active,
	input logic        tx_valid,
	input logic        tx_ready,
	input logic        usba_oe_n,
	input logic        usba_vp_out,
	input logic        usba_vm_out,
	input logic        usbb_oe_n,
	input logic        usbb_vp_out,
	input logic        usbb_vm_out,
	input logic        usba_discon,
	input logic        usbb_discon,
	input line_state_t line_state_a,
	input line_state_t line_state_b
);

	// ------------------------------
	// handshakes
	// ------------------------------

	// a byte strobe only belongs inside a packet.
	rx_valid_in_packet: assert property (@(posedge usb_clk) disable iff (usb_rst)
		rx_valid |-> rx_active) else $error("rx_valid while rx_active is low");

	// a byte is only accepted while the host offers one, and the pulse lasts one cycle.
	tx_ready_with_valid: assert property (@(posedge usb_clk) disable iff (usb_rst)
		tx_ready |-> (tx_valid ##1 !tx_ready))
		else $error("tx_ready without tx_valid or longer than one cycle");

	// ------------------------------
	// line levels
	// ------------------------------

	// se1 is never a legal symbol for a full-speed driver.
	port_a_no_se1: assert property (@(posedge usb_clk) disable iff (usb_rst)
		!usba_oe_n |-> !(usba_vp_out && usba_vm_out)) else $error("port a drives se1");

	port_b_no_se1: assert property (@(posedge usb_clk) disable iff (usb_rst)
		!usbb_oe_n |-> !(usbb_vp_out && usbb_vm_out)) else $error("port b drives se1");

	// a disconnect is only reported while the pair sits at se0, and had already been.
	port_a_discon_se0: assert property (@(posedge usb_clk) disable iff (usb_rst)
		usba_discon |-> (line_state_a == se0) && $past(line_state_a == se0))
		else $error("usba_discon without se0");

	port_b_discon_se0: assert property (@(posedge usb_clk) disable iff (usb_rst)
		usbb_discon |-> (line_state_b == se0) && $past(line_state_b == se0))
		else $error("usbb_discon without se0");

endmodule

bind usb_phy usb_phy_chk chk_i (
	.usb_clk      (usb_clk),
	.usb_rst      (usb_rst),
	.rx_valid     (rx_valid),
	.rx_active    (rx_active),
	.tx_valid     (tx_valid),
	.tx_ready     (tx_ready),
	.usba_oe_n    (usba_oe_n),
	.usba_vp_out  (usba_vp_out),
	.usba_vm_out  (usba_vm_out),
	.usbb_oe_n    (usbb_oe_n),
	.usbb_vp_out  (usbb_vp_out),
	.usbb_vm_out  (usbb_vm_out),
	.usba_discon  (usba_discon),
	.usbb_discon  (usbb_discon),
	.line_state_a (line_state_a),
	.line_state_b (line_state_b)
);

//--- sim/usb_phy_tb.sv
// USB PHY testbench
`timescale 1ns/1ps

module usb_phy_tb import usb_phy_pkg::*; ();

	// one packet of the stimulus table, byte 0 in the low bits of bytes.
	typedef struct packed {
		logic        is_tx;
		logic        port;
		logic [2:0]  len;
		logic [31:0] bytes;
	} pkt_t;

	localparam int NUM_PKTS = 4;

	// 8'hFF and 8'hFC force stuffing, 8'hFC even right before the eop.
	localparam pkt_t PKT_TABLE [NUM_PKTS] = '{
		'{1'b1, 1'b0, 3'd3, 32'h0000_FFA5},
		'{1'b1, 1'b1, 3'd2, 32'h0000_FC00},
		'{1'b0, 1'b1, 3'd4, 32'hFC7E_00FF},
		'{1'b0, 1'b1, 3'd2, 32'h0000_5AFF}
	};

	logic        usb_clk;
	logic        usb_rst;
	logic        usba_vp_in;
	logic        usba_vm_in;
	logic        usba_vp_out;
	logic        usba_vm_out;
	logic        usba_oe_n;
	logic        usbb_vp_in;
	logic        usbb_vm_in;
	logic        usbb_vp_out;
	logic        usbb_vm_out;
	logic        usbb_oe_n;
	logic        usba_discon;
	logic        usbb_discon;
	line_state_t line_state_a;
	line_state_t line_state_b;
	logic        port_sel_rx;
	logic [1:0]  port_sel_tx;
	logic [7:0]  tx_data;
	logic        tx_valid;
	logic        tx_ready;
	logic        generate_reset;
	logic [7:0]  rx_data;
	logic        rx_valid;
	logic        rx_active;

	// line symbols, one per bit, and the decoded results.
	line_state_t sym_q[$];
	line_state_t smp_q[$];
	logic        bits_q[$];
	logic [7:0]  rx_q[$];
	logic        enc_level;

	usb_phy #(
		.DISCON_CYCLES (40)
	) dut_i (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.usba_vp_in     (usba_vp_in),
		.usba_vm_in     (usba_vm_in),
		.usba_vp_out    (usba_vp_out),
		.usba_vm_out    (usba_vm_out),
		.usba_oe_n      (usba_oe_n),
		.usbb_vp_in     (usbb_vp_in),
		.usbb_vm_in     (usbb_vm_in),
		.usbb_vp_out    (usbb_vp_out),
		.usbb_vm_out    (usbb_vm_out),
		.usbb_oe_n      (usbb_oe_n),
		.usba_discon    (usba_discon),
		.usbb_discon    (usbb_discon),
		.line_state_a   (line_state_a),
		.line_state_b   (line_state_b),
		.port_sel_rx    (port_sel_rx),
		.port_sel_tx    (port_sel_tx),
		.tx_data        (tx_data),
		.tx_valid       (tx_valid),
		.tx_ready       (tx_ready),
		.generate_reset (generate_reset),
		.rx_data        (rx_data),
		.rx_valid       (rx_valid),
		.rx_active      (rx_active)
	);

	// 100 ns period.
	initial begin
		usb_clk = 1'b0;
		forever #50 usb_clk = ~usb_clk;
	end

	// ------------------------------
	// reporting and compare tasks
	// ------------------------------

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_line_state(input string name, input line_state_t got,
	                                input line_state_t exp);
		if (got !== exp) begin
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	// ------------------------------
	// line encoder and decoder
	// ------------------------------

	function automatic logic [7:0] pkt_byte(input pkt_t p, input int n);
		return p.bytes[8*n +: 8];
	endfunction

	// NRZI holds the level for a one and toggles it for a zero.
	task automatic push_bit(input logic b);
		if (!b) begin
			enc_level = ~enc_level;
		end
		sym_q.push_back(enc_level ? j : k);
	endtask

	// sync, then the bytes lsb first, with a zero after every six ones.
	task automatic build_symbols(input pkt_t p);
		logic [7:0] b;
		int         n;
		int         i;
		int         ones;
		sym_q.delete();
		enc_level = 1'b1;
		ones = 0;
		for (n = 0; n <= int'(p.len); n++) begin
			b = (n == 0) ? SYNC_BYTE : pkt_byte(p, n - 1);
			for (i = 0; i < 8; i++) begin
				push_bit(b[i]);
				ones = b[i] ? ones + 1 : 0;
				if (ones == 6) begin
					push_bit(1'b0);
					ones = 0;
				end
			end
		end
		// eop is two bit times of se0 and one of j.
		sym_q.push_back(se0);
		sym_q.push_back(se0);
		sym_q.push_back(j);
	endtask

	// smp_q holds one sample per cycle of the driven pair, so the middle of
	// bit m sits at index 4*m+2.
	task automatic check_tx_line(input pkt_t p);
		logic [1:0] ls;
		logic       prev_dp;
		logic       dec_bit;
		logic [7:0] b;
		int         ones;
		int         i;
		int         n;
		int         m;
		bits_q.delete();
		prev_dp = 1'b1;
		ones = 0;
		i = 2;
		while (i < smp_q.size() && smp_q[i] != se0) begin
			ls = smp_q[i];
			dec_bit = (ls[0] == prev_dp);
			prev_dp = ls[0];
			if (ones == 6) begin
				check_level("stuffed bit", dec_bit, 1'b0);
				ones = 0;
			end else begin
				bits_q.push_back(dec_bit);
				ones = dec_bit ? ones + 1 : 0;
			end
			i += 4;
		end
		check_byte("tx bit count", 8'(bits_q.size()), 8'(8 * (int'(p.len) + 1)));
		for (n = 0; n <= int'(p.len); n++) begin
			for (m = 0; m < 8; m++) begin
				b[m] = bits_q[8*n + m];
			end
			check_byte((n == 0) ? "tx sync" : "tx byte", b,
			           (n == 0) ? SYNC_BYTE : pkt_byte(p, n - 1));
		end
		if (smp_q.size() < i + 10) begin
			fail_now("the transmitter released the port before a complete eop");
		end
		check_line_state("eop bit 1", smp_q[i], se0);
		check_line_state("eop bit 2", smp_q[i + 4], se0);
		check_line_state("eop idle bit", smp_q[i + 8], j);
		if (smp_q.size() != i + 10) begin
			fail_now("oe_n stayed low longer than one j bit after the eop");
		end
	endtask

	// ------------------------------
	// packet drivers
	// ------------------------------

	task automatic drive_line(input logic port, input line_state_t ls);
		if (port) begin
			usbb_vp_in <= ls[0];
			usbb_vm_in <= ls[1];
		end else begin
			usba_vp_in <= ls[0];
			usba_vm_in <= ls[1];
		end
	endtask

	// feeds the bytes on tx_ready and records the selected pair while it drives.
	task automatic run_tx(input pkt_t p);
		logic own_oe_n;
		logic advance;
		logic seen_oe;
		logic done;
		int   idx;
		int   cyc;
		smp_q.delete();
		seen_oe = 1'b0;
		done = 1'b0;
		idx = 0;
		cyc = 0;
		@(posedge usb_clk);
		port_sel_tx <= p.port ? 2'b10 : 2'b01;
		tx_data     <= pkt_byte(p, 0);
		tx_valid    <= 1'b1;
		while (!done) begin
			@(negedge usb_clk);
			cyc++;
			own_oe_n = p.port ? usbb_oe_n : usba_oe_n;
			check_level("oe_n of the idle port", p.port ? usba_oe_n : usbb_oe_n, 1'b1);
			// txoe follows one cycle after tx_valid reaches the transmitter.
			if (cyc == 1) begin
				check_level("oe_n before txoe rise", own_oe_n, 1'b1);
			end
			if (cyc == 2) begin
				check_level("oe_n at txoe rise", own_oe_n, 1'b0);
			end
			if (!own_oe_n) begin
				seen_oe = 1'b1;
				smp_q.push_back(p.port ? line_state_t'({usbb_vm_out, usbb_vp_out}) :
				                         line_state_t'({usba_vm_out, usba_vp_out}));
			end else if (seen_oe) begin
				done = 1'b1;
			end
			advance = tx_ready;
			if (cyc > 400) begin
				fail_now("timeout waiting for the transmitter to release the port");
			end
			if (!done) begin
				@(posedge usb_clk);
				if (advance) begin
					idx++;
					if (idx < int'(p.len)) begin
						tx_data <= pkt_byte(p, idx);
					end else begin
						tx_valid <= 1'b0;
					end
				end
			end
		end
		check_byte("tx_ready pulse count", 8'(idx), {5'd0, p.len});
	endtask

	// plays the symbols at four cycles per bit and gathers every strobed byte.
	task automatic run_rx(input pkt_t p);
		int s;
		int c;
		int n;
		rx_q.delete();
		build_symbols(p);
		@(posedge usb_clk);
		port_sel_rx <= p.port;
		for (s = 0; s < sym_q.size(); s++) begin
			for (c = 0; c < 4; c++) begin
				@(posedge usb_clk);
				if (c == 0) begin
					drive_line(p.port, sym_q[s]);
				end
				@(negedge usb_clk);
				if (rx_valid) begin
					rx_q.push_back(rx_data);
				end
			end
		end
		n = 0;
		while (rx_active) begin
			@(negedge usb_clk);
			n++;
			if (rx_valid) begin
				rx_q.push_back(rx_data);
			end
			if (n >= 50) begin
				fail_now("timeout waiting for rx_active to fall after the eop");
			end
		end
		check_byte("rx byte count", 8'(rx_q.size()), {5'd0, p.len});
		for (s = 0; s < int'(p.len); s++) begin
			check_byte("rx_data", rx_q[s], pkt_byte(p, s));
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin : main
		int n;
		int e;
		usb_rst        = 1'b1;
		usba_vp_in     = 1'b1;
		usba_vm_in     = 1'b0;
		usbb_vp_in     = 1'b1;
		usbb_vm_in     = 1'b0;
		port_sel_rx    = 1'b0;
		port_sel_tx    = 2'b00;
		tx_data        = 8'h00;
		tx_valid       = 1'b0;
		generate_reset = 1'b0;
		repeat (10) @(posedge usb_clk);
		usb_rst <= 1'b0;

		// quiet outputs after reset, and j on both ports.
		@(negedge usb_clk);
		check_level("usba_oe_n", usba_oe_n, 1'b1);
		check_level("usbb_oe_n", usbb_oe_n, 1'b1);
		check_level("tx_ready", tx_ready, 1'b0);
		check_level("rx_valid", rx_valid, 1'b0);
		check_level("rx_active", rx_active, 1'b0);
		check_level("usba_discon", usba_discon, 1'b0);
		check_level("usbb_discon", usbb_discon, 1'b0);
		n = 0;
		while (line_state_a != j) begin
			@(negedge usb_clk);
			n++;
			if (n > 4) begin
				fail_now("timeout waiting for line_state_a to read j");
			end
		end
		repeat (8) begin
			@(negedge usb_clk);
			check_line_state("line_state_a", line_state_a, j);
			check_line_state("line_state_b", line_state_b, j);
		end

		for (e = 0; e < NUM_PKTS; e++) begin
			if (PKT_TABLE[e].is_tx) begin
				run_tx(PKT_TABLE[e]);
				check_tx_line(PKT_TABLE[e]);
			end else begin
				run_rx(PKT_TABLE[e]);
			end
			repeat (8) @(posedge usb_clk);
		end

		// a short se0 is not a disconnect, a long one is.
		@(posedge usb_clk);
		drive_line(1'b0, se0);
		repeat (30) begin
			@(negedge usb_clk);
			check_level("usba_discon", usba_discon, 1'b0);
		end
		n = 0;
		while (!usba_discon) begin
			@(negedge usb_clk);
			n++;
			if (n >= 60) begin
				fail_now("timeout waiting for usba_discon to rise");
			end
		end
		@(posedge usb_clk);
		drive_line(1'b0, j);
		n = 0;
		while (usba_discon) begin
			@(negedge usb_clk);
			n++;
			if (n > 6 || (usba_discon && n == 6)) begin
				fail_now("timeout waiting for usba_discon to clear");
			end
		end

		// bus reset drives se0 on port a for as long as it is requested.
		@(posedge usb_clk);
		port_sel_tx    <= 2'b01;
		generate_reset <= 1'b1;
		n = 0;
		while (usba_oe_n) begin
			@(negedge usb_clk);
			n++;
			if (usba_oe_n && n >= 4) begin
				fail_now("timeout waiting for usba_oe_n to go low for bus reset");
			end
		end
		repeat (40) begin
			check_level("usba_oe_n", usba_oe_n, 1'b0);
			check_line_state("usba out pins", line_state_t'({usba_vm_out, usba_vp_out}), se0);
			check_level("tx_ready", tx_ready, 1'b0);
			@(negedge usb_clk);
		end
		@(posedge usb_clk);
		generate_reset <= 1'b0;
		n = 0;
		while (!usba_oe_n) begin
			@(negedge usb_clk);
			n++;
			if (!usba_oe_n && n >= 4) begin
				fail_now("timeout waiting for usba_oe_n to return high after bus reset");
			end
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- project.f
hw/usb_phy_pkg.sv
hw/usb_line_filter.sv
hw/usb_discon_detect.sv
hw/usb_tx.sv
hw/usb_rx.sv
hw/usb_phy.sv
sim/usb_phy_chk.sv
sim/usb_phy_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module usb_phy_tb -f project.f -o usb_phy_sim

# the simulator exits non-zero on a failure, so its status is taken from the log
./obj_dir/usb_phy_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
	echo "simulation did not complete"
	exit 1
fi
echo "simulation passed"
